// File: packet_audit_patterns.txt
# L dest blen crc | B data keep last dest | E matched index dest blen
# C matched unmatched outstanding | X clear | all fields hex
L 0 9 29b1
L 0 1 b915
L 1 9 29b1
L 2 9 29b1
L 3 9 29b1
L 3 9 29b1
L 1 9 29b1
L 2 1 b915
C 0 0 8
# Odd lengths on one destination
E 1 0 0 9
B 34333231 f 0 0
B 38373635 f 0 0
B 00000039 1 1 0
E 1 1 0 1
B 00000041 1 1 0
# Two destinations interleaved
E 1 2 1 9
E 1 3 2 9
B 34333231 f 0 1
B 34333231 f 0 2
B 38373635 f 0 1
B 38373635 f 0 2
B 00000039 1 1 1
B 00000039 1 1 2
# Repeat of a packet loaded once
E 0 0 0 9
B 34333231 f 0 0
B 38373635 f 0 0
B 00000039 1 1 0
# Two identical descriptors, then one more copy
E 1 4 3 9
B 34333231 f 0 3
B 38373635 f 0 3
B 00000039 1 1 3
E 1 5 3 9
B 34333231 f 0 3
B 38373635 f 0 3
B 00000039 1 1 3
E 0 0 3 9
B 34333231 f 0 3
B 38373635 f 0 3
B 00000039 1 1 3
# Corrupted last byte, short packet, then the good one
E 0 0 1 9
B 34333231 f 0 1
B 38373635 f 0 1
B 00000030 1 1 1
E 0 0 1 8
B 34333231 f 0 1
B 38373635 f 1 1
E 1 6 1 9
B 34333231 f 0 1
B 38373635 f 0 1
B 00000039 1 1 1
C 7 4 1
X
C 0 0 0
E 0 0 0 1
B 00000041 1 1 0
L 0 1 b915
C 0 1 1
E 1 0 0 1
B 00000041 1 1 0
C 1 1 0

// File: packet_audit.f
packet_audit_pkg.sv
stream_reassembler.sv
expected_matcher.sv
audit_counters.sv
packet_audit.sv
packet_audit_properties.sv
packet_audit_checker.sv
packet_audit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timescale 1ns/10ps
TOP       ?= packet_audit_tb
FILELIST  ?= packet_audit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Errors found" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: packet_audit_tb.sv
/* Testbench top for the packet audit block: clock, reset, pattern file
   replay with falling-edge stimulus, random idle gaps and a cycle limit */

`timescale 1ns/10ps

module packet_audit_tb;

    logic                                     axis_packet_in;
    logic                                     rst;
    logic                                     clear;
    logic                                     load_valid;
    logic                                     beat_valid;
    packet_audit_pkg::stream_beat_t           beat;
    packet_audit_pkg::expected_desc_t         load_desc;
    logic                                     beat_ready;
    packet_audit_pkg::audit_result_t          result;
    logic                                     result_valid;
    logic [packet_audit_pkg::count_width-1:0] matched_count;
    logic [packet_audit_pkg::count_width-1:0] unmatched_count;
    logic [packet_audit_pkg::count_width-1:0] outstanding_count;

    int          cycle_count;
    int          cycle_limit;
    int          file_errors;
    logic [31:0] lcg_state;

    packet_audit packet_audit_inst (
        .axis_packet_in    (axis_packet_in),
        .rst               (rst),
        .clear             (clear),
        .load_valid        (load_valid),
        .beat_valid        (beat_valid),
        .beat              (beat),
        .load_desc         (load_desc),
        .beat_ready        (beat_ready),
        .result            (result),
        .result_valid      (result_valid),
        .matched_count     (matched_count),
        .unmatched_count   (unmatched_count),
        .outstanding_count (outstanding_count)
    );

    packet_audit_checker checker_inst (
        .axis_packet_in    (axis_packet_in),
        .rst               (rst),
        .result            (result),
        .result_valid      (result_valid),
        .matched_count     (matched_count),
        .unmatched_count   (unmatched_count),
        .outstanding_count (outstanding_count)
    );

    //////////////////////////////////////////////////
    // Clock and cycle limit

    initial axis_packet_in = 1'b0;
    always #20 axis_packet_in = ~axis_packet_in;

    always @(posedge axis_packet_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers

    // 0 to 2 idle cycles before each beat
    function automatic int idle_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]) % 3;
    endfunction

    // Returns once the matcher is idle, just after a falling edge
    task automatic wait_idle();
        beat_valid = 1'b0;
        @(negedge axis_packet_in);
        while (!beat_ready) @(negedge axis_packet_in);
        @(negedge axis_packet_in);
    endtask

    // Beat is held until ready is seen high for a whole cycle
    task automatic send_beat(input logic [31:0] data, input logic [3:0] keep,
                             input logic last, input logic [1:0] dest);
        int gap;
        gap = idle_gap();
        beat_valid = 1'b0;
        repeat (gap) @(negedge axis_packet_in);
        beat.data  = data;
        beat.keep  = keep;
        beat.last  = last;
        beat.dest  = dest;
        beat_valid = 1'b1;
        while (!beat_ready) @(negedge axis_packet_in);
        @(negedge axis_packet_in);
        beat_valid = 1'b0;
    endtask

    // Cycle budget from the number of beats and packets in the file
    task automatic size_run();
        int          fd;
        int          n;
        int          beats;
        int          packets;
        string       line;
        byte         tag;
        logic [31:0] f1, f2, f3, f4;
        beats   = 0;
        packets = 0;
        fd = $fopen("packet_audit_patterns.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("Could not open the pattern file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "B") begin
                    n = $sscanf(line, "%c %h %h %h %h", tag, f1, f2, f3, f4);
                    beats++;
                    if (f3[0]) packets++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 3 * (beats + 10 * packets) + 100;
    endtask

    task automatic replay_patterns();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] f1, f2, f3, f4;
        fd = $fopen("packet_audit_patterns.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                f1 = '0;
                f2 = '0;
                f3 = '0;
                f4 = '0;
                n = $sscanf(line, "%c %h %h %h %h", tag, f1, f2, f3, f4);
                case (tag)
                    "L": begin
                        wait_idle();
                        load_desc.dest = f1[1:0];
                        load_desc.blen = f2[10:0];
                        load_desc.crc  = f3[15:0];
                        load_valid     = 1'b1;
                        @(negedge axis_packet_in);
                        load_valid     = 1'b0;
                    end
                    "B": send_beat(f1, f2[3:0], f3[0], f4[1:0]);
                    "E": checker_inst.expect_result(f1[0], f2[2:0], f3[1:0], f4[10:0]);
                    "C": begin
                        wait_idle();
                        checker_inst.check_counts(f1[7:0], f2[7:0], f3[7:0]);
                    end
                    "X": begin
                        wait_idle();
                        clear = 1'b1;
                        @(negedge axis_packet_in);
                        clear = 1'b0;
                    end
                    default: begin
                        file_errors++;
                        $display("Unknown record in the pattern file: %s", line);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst         = 1'b1;
        clear       = 1'b0;
        load_valid  = 1'b0;
        beat_valid  = 1'b0;
        beat        = '0;
        load_desc   = '0;
        cycle_count = 0;
        cycle_limit = 0;
        file_errors = 0;
        lcg_state   = 32'd29457;
        size_run();
        repeat (8) @(negedge axis_packet_in);
        rst = 1'b0;
        replay_patterns();
        wait_idle();
        checker_inst.report_missing();
        $display("Error counts: %0d value, %0d result sequence, %0d pattern file",
                 checker_inst.value_errors, checker_inst.sequence_errors, file_errors);
        if (checker_inst.value_errors + checker_inst.sequence_errors + file_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: packet_audit_checker.sv
/* Result and counter checker: compares each audit result with the queued
   expectations and the counts at each count record */

`timescale 1ns/10ps

module packet_audit_checker (
    input logic                                     axis_packet_in,
    input logic                                     rst,
    input packet_audit_pkg::audit_result_t          result,
    input logic                                     result_valid,
    input logic [packet_audit_pkg::count_width-1:0] matched_count,
    input logic [packet_audit_pkg::count_width-1:0] unmatched_count,
    input logic [packet_audit_pkg::count_width-1:0] outstanding_count
);

    int value_errors    = 0;
    int sequence_errors = 0;

    packet_audit_pkg::audit_result_t expected_q[$];
    packet_audit_pkg::audit_result_t want;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic expect_result(input logic matched, input logic [2:0] index,
                                 input logic [1:0] dest, input logic [10:0] blen);
        packet_audit_pkg::audit_result_t r;
        r.matched = matched;
        r.index   = index;
        r.dest    = dest;
        r.blen    = blen;
        expected_q.push_back(r);
    endtask

    task automatic check_counts(input logic [7:0] matched, input logic [7:0] unmatched,
                                input logic [7:0] outstanding);
        compare_field("matched_count", 32'(matched), 32'(matched_count));
        compare_field("unmatched_count", 32'(unmatched), 32'(unmatched_count));
        compare_field("outstanding_count", 32'(outstanding), 32'(outstanding_count));
    endtask

    task automatic report_missing();
        packet_audit_pkg::audit_result_t r;
        while (expected_q.size() > 0) begin
            r = expected_q.pop_front();
            sequence_errors++;
            $display("Missing result: a packet for dest %0d with length %0d gave no result",
                     r.dest, r.blen);
        end
    endtask

    // Each result pulse against the oldest expectation
    always @(negedge axis_packet_in) begin
        if (!rst && result_valid) begin
            if (expected_q.size() == 0) begin
                sequence_errors++;
                $display("Unexpected result: result_valid pulsed with nothing expected");
            end else begin
                want = expected_q.pop_front();
                compare_field("result.matched", 32'(want.matched), 32'(result.matched));
                compare_field("result.index", 32'(want.index), 32'(result.index));
                compare_field("result.dest", 32'(want.dest), 32'(result.dest));
                compare_field("result.blen", 32'(want.blen), 32'(result.blen));
            end
        end
    end

endmodule

// File: packet_audit_properties.sv
/* Stream and result protocol assertions, bound into the packet audit top */

`timescale 1ns/10ps

module packet_audit_properties (
    input logic                           axis_packet_in,
    input logic                           rst,
    input logic                           beat_valid,
    input logic                           beat_ready,
    input logic                           beat_accept,
    input packet_audit_pkg::stream_beat_t beat,
    input logic                           result_valid
);

    result_single_pulse: assert property (@(posedge axis_packet_in) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid held for more than one cycle");

    // Stream stalls while the summary is searched
    ready_low_after_last: assert property (@(posedge axis_packet_in) disable iff (rst)
        beat_accept && beat.last |=> !beat_ready)
        else $error("beat_ready still high in the cycle after a last beat");

    ready_back_after_result: assert property (@(posedge axis_packet_in) disable iff (rst)
        result_valid |=> beat_ready)
        else $error("beat_ready not restored in the cycle after a result");

    keep_nonzero: assert property (@(posedge axis_packet_in) disable iff (rst)
        beat_valid |-> beat.keep != '0)
        else $error("valid beat with an empty keep mask");

    // Source holds a stalled beat
    beat_held: assert property (@(posedge axis_packet_in) disable iff (rst)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
        else $error("stalled beat changed before acceptance");

endmodule

bind packet_audit packet_audit_properties packet_audit_properties_inst (
    .axis_packet_in (axis_packet_in),
    .rst            (rst),
    .beat_valid     (beat_valid),
    .beat_ready     (beat_ready),
    .beat_accept    (beat_accept),
    .beat           (beat),
    .result_valid   (result_valid)
);

// File: packet_audit.sv
/* Receive-side packet audit top level: reassembler, descriptor matcher and
   counters, with stream ready driven from the matcher's search state */

`timescale 1ns/10ps

module packet_audit (
    input  logic                                     axis_packet_in,
    input  logic                                     rst,
    input  logic                                     clear,
    input  logic                                     load_valid,
    input  logic                                     beat_valid,
    input  packet_audit_pkg::stream_beat_t           beat,
    input  packet_audit_pkg::expected_desc_t         load_desc,
    output logic                                     beat_ready,
    output packet_audit_pkg::audit_result_t          result,
    output logic                                     result_valid,
    output logic [packet_audit_pkg::count_width-1:0] matched_count,
    output logic [packet_audit_pkg::count_width-1:0] unmatched_count,
    output logic [packet_audit_pkg::count_width-1:0] outstanding_count
);

    packet_audit_pkg::packet_summary_t summary;
    logic                              summary_valid;
    logic                              busy;
    logic                              beat_accept;
    logic                              load_accept;
    logic                              load_accepted;

    // No new beats while a search is pending
    assign beat_ready    = !busy && !rst;
    assign beat_accept   = beat_valid && beat_ready;
    assign load_accepted = load_valid && load_accept;

    stream_reassembler stream_reassembler_inst (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .beat           (beat),
        .beat_accept    (beat_accept),
        .summary        (summary),
        .summary_valid  (summary_valid)
    );

    expected_matcher expected_matcher_inst (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .clear          (clear),
        .load_desc      (load_desc),
        .load_valid     (load_valid),
        .load_accept    (load_accept),
        .summary        (summary),
        .summary_valid  (summary_valid),
        .busy           (busy),
        .result         (result),
        .result_valid   (result_valid)
    );

    audit_counters audit_counters_inst (
        .axis_packet_in    (axis_packet_in),
        .rst               (rst),
        .clear             (clear),
        .load_accepted     (load_accepted),
        .result            (result),
        .result_valid      (result_valid),
        .matched_count     (matched_count),
        .unmatched_count   (unmatched_count),
        .outstanding_count (outstanding_count)
    );

endmodule

// File: audit_counters.sv
/* Saturating matched and unmatched totals, plus the count of loaded
   descriptors still waiting for a packet */

`timescale 1ns/10ps

module audit_counters (
    input  logic                                     axis_packet_in,
    input  logic                                     rst,
    input  logic                                     clear,
    input  logic                                     load_accepted,
    input  packet_audit_pkg::audit_result_t          result,
    input  logic                                     result_valid,
    output logic [packet_audit_pkg::count_width-1:0] matched_count,
    output logic [packet_audit_pkg::count_width-1:0] unmatched_count,
    output logic [packet_audit_pkg::count_width-1:0] outstanding_count
);

    logic match_seen;

    assign match_seen = result_valid && result.matched;

    always_ff @(posedge axis_packet_in) begin
        if (rst || clear) begin
            matched_count     <= '0;
            unmatched_count   <= '0;
            outstanding_count <= '0;
        end else begin
            // Hold at full scale
            if (match_seen && matched_count != '1) begin
                matched_count <= matched_count + 1'b1;
            end
            if (result_valid && !result.matched && unmatched_count != '1) begin
                unmatched_count <= unmatched_count + 1'b1;
            end
            case ({load_accepted, match_seen})
                2'b10:   outstanding_count <= outstanding_count + 1'b1;
                2'b01: begin
                    if (outstanding_count != '0) begin
                        outstanding_count <= outstanding_count - 1'b1;
                    end
                end
                default: outstanding_count <= outstanding_count;
            endcase
        end
    end

endmodule

// File: expected_matcher.sv
/* Table of expected packet descriptors with received flags, searched one entry
   per cycle for each completed packet summary */

`timescale 1ns/10ps

module expected_matcher (
    input  logic                              axis_packet_in,
    input  logic                              rst,
    input  logic                              clear,
    input  packet_audit_pkg::expected_desc_t  load_desc,
    input  logic                              load_valid,
    output logic                              load_accept,
    input  packet_audit_pkg::packet_summary_t summary,
    input  logic                              summary_valid,
    output logic                              busy,
    output packet_audit_pkg::audit_result_t   result,
    output logic                              result_valid
);

    //////////////////////////////////////////////////
    // Table and search state

    packet_audit_pkg::expected_desc_t table_mem [packet_audit_pkg::num_expected];

    logic [packet_audit_pkg::num_expected-1:0] received;
    logic [packet_audit_pkg::idx_width:0]      loaded_count;
    logic                                      searching;
    logic [packet_audit_pkg::idx_width-1:0]    scan_idx;
    packet_audit_pkg::packet_summary_t         captured;

    packet_audit_pkg::expected_desc_t          entry;
    logic [packet_audit_pkg::idx_width-1:0]    last_idx;
    logic                                      table_full;
    logic                                      in_range;
    logic                                      entry_hit;
    logic                                      scan_done;
    logic                                      start_search;
    logic                                      load_write;

    //////////////////////////////////////////////////
    // Compare logic

    assign table_full = loaded_count ==
        (packet_audit_pkg::idx_width + 1)'(packet_audit_pkg::num_expected);
    assign last_idx   = loaded_count[packet_audit_pkg::idx_width-1:0] - 1'b1;
    assign entry      = table_mem[scan_idx];
    assign in_range   = {1'b0, scan_idx} < loaded_count;

    // Only unreceived entries can take a packet
    assign entry_hit = in_range && !received[scan_idx]
                    && entry.dest == captured.dest
                    && entry.blen == captured.blen
                    && entry.crc  == captured.crc;

    // Empty table ends on the first scan cycle
    assign scan_done = entry_hit || !in_range || scan_idx == last_idx;

    // Busy from the summary cycle through the result cycle
    assign busy         = searching || summary_valid;
    assign start_search = summary_valid && !searching;
    assign load_accept  = !table_full && !busy;
    assign load_write   = load_valid && load_accept;

    assign result_valid   = searching && scan_done;
    assign result.matched = entry_hit;
    assign result.index   = entry_hit ? scan_idx : '0;
    assign result.dest    = captured.dest;
    assign result.blen    = captured.blen;

    //////////////////////////////////////////////////
    // Control state

    always_ff @(posedge axis_packet_in) begin
        if (rst || clear) begin
            searching    <= 1'b0;
            scan_idx     <= '0;
            loaded_count <= '0;
            received     <= '0;
        end else begin
            if (start_search) begin
                searching <= 1'b1;
                scan_idx  <= '0;
            end else if (searching) begin
                if (scan_done) begin
                    searching <= 1'b0;
                    if (entry_hit) begin
                        received[scan_idx] <= 1'b1;
                    end
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                end
            end
            if (load_write) begin
                loaded_count <= loaded_count + 1'b1;
            end
        end
    end

    // Descriptor storage and captured summary
    always_ff @(posedge axis_packet_in) begin
        if (load_write) begin
            table_mem[loaded_count[packet_audit_pkg::idx_width-1:0]] <= load_desc;
        end
        if (start_search) begin
            captured <= summary;
        end
    end

endmodule

// File: stream_reassembler.sv
/* Per-destination byte count and CRC accumulation over accepted stream beats,
   with a registered summary pulse at the end of each packet */

`timescale 1ns/10ps

module stream_reassembler (
    input  logic                             axis_packet_in,
    input  logic                             rst,
    input  packet_audit_pkg::stream_beat_t   beat,
    input  logic                             beat_accept,
    output packet_audit_pkg::packet_summary_t summary,
    output logic                             summary_valid
);

    //////////////////////////////////////////////////
    // Accumulator state

    // One running count and CRC per destination
    logic [packet_audit_pkg::blen_width-1:0] byte_count [packet_audit_pkg::num_dests];
    logic [packet_audit_pkg::crc_width-1:0]  crc_acc    [packet_audit_pkg::num_dests];

    logic [packet_audit_pkg::blen_width-1:0] beat_bytes;
    logic [packet_audit_pkg::blen_width-1:0] next_count;
    logic [packet_audit_pkg::crc_width-1:0]  next_crc;

    //////////////////////////////////////////////////
    // Beat contribution

    // Kept bytes are walked low to high
    always_comb begin
        beat_bytes = '0;
        next_crc   = crc_acc[beat.dest];
        for (int i = 0; i < packet_audit_pkg::data_bytes; i++) begin
            if (beat.keep[i]) begin
                next_crc   = packet_audit_pkg::crc16_step(next_crc, beat.data[8*i +: 8]);
                beat_bytes = beat_bytes + 1'b1;
            end
        end
        next_count = byte_count[beat.dest] + beat_bytes;
    end

    //////////////////////////////////////////////////
    // Accumulator update

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            for (int d = 0; d < packet_audit_pkg::num_dests; d++) begin
                byte_count[d] <= '0;
                crc_acc[d]    <= packet_audit_pkg::crc_init;
            end
        end else if (beat_accept) begin
            if (beat.last) begin
                // Ready for the next packet on this destination
                byte_count[beat.dest] <= '0;
                crc_acc[beat.dest]    <= packet_audit_pkg::crc_init;
            end else begin
                byte_count[beat.dest] <= next_count;
                crc_acc[beat.dest]    <= next_crc;
            end
        end
    end

    // Pulse for one cycle after the last beat
    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            summary_valid <= 1'b0;
        end else begin
            summary_valid <= beat_accept && beat.last;
        end
    end

    // Summary payload, held until the next packet ends
    always_ff @(posedge axis_packet_in) begin
        if (beat_accept && beat.last) begin
            summary.dest <= beat.dest;
            summary.blen <= next_count;
            summary.crc  <= next_crc;
        end
    end

endmodule

// File: packet_audit_pkg.sv
/* Sizing constants, stream and audit record structs, and the CRC-16-CCITT byte step
   shared by the packet audit blocks */

package packet_audit_pkg;

    //////////////////////////////////////////////////
    // Sizing

    localparam int data_bytes   = 4;
    localparam int dest_width   = 2;
    localparam int num_dests    = 4;
    localparam int blen_width   = 11;
    localparam int num_expected = 8;
    localparam int idx_width    = 3;
    localparam int count_width  = 8;

    // CRC-16-CCITT, MSB first
    localparam int          crc_width = 16;
    localparam logic [15:0] crc_poly  = 16'h1021;
    localparam logic [15:0] crc_init  = 16'hFFFF;

    //////////////////////////////////////////////////
    // Records

    typedef struct packed {
        logic [data_bytes*8-1:0] data;
        logic [data_bytes-1:0]   keep;
        logic                    last;
        logic [dest_width-1:0]   dest;
    } stream_beat_t;

    typedef struct packed {
        logic [dest_width-1:0] dest;
        logic [blen_width-1:0] blen;
        logic [crc_width-1:0]  crc;
    } expected_desc_t;

    // Same fields as a descriptor, but taken from the wire
    typedef struct packed {
        logic [dest_width-1:0] dest;
        logic [blen_width-1:0] blen;
        logic [crc_width-1:0]  crc;
    } packet_summary_t;

    typedef struct packed {
        logic                  matched;
        logic [idx_width-1:0]  index;
        logic [dest_width-1:0] dest;
        logic [blen_width-1:0] blen;
    } audit_result_t;

    //////////////////////////////////////////////////
    // CRC byte step

    function automatic logic [crc_width-1:0] crc16_step(
        input logic [crc_width-1:0] crc_in,
        input logic [7:0]           data_byte
    );
        logic [crc_width-1:0] crc;
        crc = crc_in ^ {data_byte, 8'h00};
        for (int b = 0; b < 8; b++) begin
            if (crc[crc_width-1]) begin
                crc = {crc[crc_width-2:0], 1'b0} ^ crc_poly;
            end else begin
                crc = {crc[crc_width-2:0], 1'b0};
            end
        end
        return crc;
    endfunction

endpackage
